// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= clkdiv_tb
FILELIST  ?= clkdiv_sub.f
OBJ_DIR   ?= obj_dir

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== clkdiv_sub.f ====
hw/clkdiv_cfg_pkg.sv
hw/clkdiv_ctrl_pkg.sv
hw/clkdiv_rst_sync.sv
hw/clkdiv_req_sync.sv
hw/clkdiv_counter.sv
hw/clkdiv_clk_gate.sv
hw/clkdiv_top.sv
verification/clkdiv_clk_gen.sv
verification/clkdiv_assert.sv
verification/clkdiv_tb.sv

// ==== hw/clkdiv_cfg_pkg.sv ====
// Ratio is 8 bits wide; ratios 0 and 1 mean bypass, and only integer ratios are supported
`default_nettype none

package clkdiv_cfg_pkg;

    //////////////////////////////
    // Ratio format
    //////////////////////////////

    // Width of the division ratio
    localparam int unsigned DIV_W = 8;

    // Ratio value as seen on the host port and in the ratio register
    typedef logic [DIV_W-1:0] div_t;

    //////////////////////////////
    // Reset and bypass rule
    //////////////////////////////

    // Ratio after reset
    localparam div_t DIV_INIT = div_t'(0);

    // Counter starts in bypass, so the fast clock is visible right out of reset
    localparam logic BYPASS_INIT = 1'b1;

    // Largest ratio that still passes the input clock straight through
    localparam div_t BYPASS_MAX = div_t'(1);

endpackage

`default_nettype wire

// ==== hw/clkdiv_clk_gate.sv ====
// Behavioral latch gate; map to a library ICG cell at synthesis, en_i must be glitch-free in clk_i
`default_nettype none

module clkdiv_clk_gate
(
    input  logic clk_i,
    input  logic en_i,
    input  logic test_en_i,
    output logic clk_o
);

    logic s_en_latch;

    //////////////////////////////
    // Low-phase latch
    //////////////////////////////

    // Transparent while the clock is low
    // Holds its value across the whole high phase
    always_latch
    begin
        if (!clk_i)
        begin
            s_en_latch = en_i | test_en_i;
        end
    end

    // Enable edges only land in the low phase, so no pulse is chopped
    assign clk_o = clk_i & s_en_latch;

endmodule

`default_nettype wire

// ==== hw/clkdiv_counter.sv ====
// Integer ratios only, duty cycle is floor(N/2) high; bypass and test mode output is clk_i itself
`default_nettype none

module clkdiv_counter
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 test_mode_i,
    input  logic                 load_i,
    input  clkdiv_cfg_pkg::div_t div_i,
    output logic                 clk_o
);

    // Ratio captured on load, count runs from 0 to ratio minus one
    clkdiv_cfg_pkg::div_t reg_div;
    clkdiv_cfg_pkg::div_t reg_cnt;
    clkdiv_cfg_pkg::div_t s_cnt_next;
    clkdiv_cfg_pkg::div_t s_half;

    logic reg_bypass;
    logic reg_clk;

    //////////////////////////////
    // Count sequencing
    //////////////////////////////

    // Number of high cycles per period, rounded down
    assign s_half = reg_div >> 1;

    // Wrap at ratio minus one
    // Count parks at zero in bypass
    always_comb
    begin
        if (reg_bypass || (reg_cnt >= reg_div - 1'b1))
        begin
            s_cnt_next = '0;
        end
        else
        begin
            s_cnt_next = reg_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Divided clock register
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            reg_div    <= clkdiv_cfg_pkg::DIV_INIT;
            reg_bypass <= clkdiv_cfg_pkg::BYPASS_INIT;
            reg_cnt    <= '0;
            reg_clk    <= 1'b0;
        end
        else if (load_i)
        begin
            // New ratio restarts the period at count zero, high phase first
            reg_div    <= div_i;
            reg_bypass <= (div_i <= clkdiv_cfg_pkg::BYPASS_MAX);
            reg_cnt    <= '0;
            reg_clk    <= ((div_i >> 1) != '0);
        end
        else
        begin
            reg_cnt <= s_cnt_next;
            // High while the upcoming count sits in the first half
            reg_clk <= !reg_bypass && (s_cnt_next < s_half);
        end
    end

    // Fast clock straight through in bypass, also visible in scan
    assign clk_o = (reg_bypass || test_mode_i) ? clk_i : reg_clk;

endmodule

`default_nettype wire

// ==== hw/clkdiv_ctrl_pkg.sv ====
// FSM encoding is fixed at 2 bits; synchronizer depth applies to all async inputs alike
`default_nettype none

package clkdiv_ctrl_pkg;

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    // Clock stop sequence around a ratio change
    // IDLE runs the clock, the other three hold it gated for one cycle each
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        STOP    = 2'd1,
        WAIT    = 2'd2,
        RELEASE = 2'd3
    } state_t;

    // Flops per synchronizer chain on async inputs
    localparam int unsigned SYNC_STAGES = 2;

endpackage

`default_nettype wire

// ==== hw/clkdiv_req_sync.sv ====
// serial_i must be a level held for several clk_i cycles; pulses shorter than a cycle can be lost
`default_nettype none

module clkdiv_req_sync
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic serial_i,
    output logic serial_o,
    output logic r_edge_o
);

    // Sync stages followed by one history flop at the top index
    logic [clkdiv_ctrl_pkg::SYNC_STAGES:0] reg_sync;
    logic                                  reg_edge;
    logic                                  s_rise;

    //////////////////////////////
    // Level synchronizer
    //////////////////////////////

    // Stage 0 may go metastable, later stages settle it
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            reg_sync <= '0;
        end
        else
        begin
            reg_sync <= {reg_sync[clkdiv_ctrl_pkg::SYNC_STAGES-1:0], serial_i};
        end
    end

    // Synchronized level is high while history is still low
    assign s_rise = reg_sync[clkdiv_ctrl_pkg::SYNC_STAGES-1]
                  & ~reg_sync[clkdiv_ctrl_pkg::SYNC_STAGES];

    // Registered pulse, lines up with the echoed level
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            reg_edge <= 1'b0;
        end
        else
        begin
            reg_edge <= s_rise;
        end
    end

    // Acknowledge echo back to the host
    assign serial_o = reg_sync[clkdiv_ctrl_pkg::SYNC_STAGES];
    assign r_edge_o = reg_edge;

endmodule

`default_nettype wire

// ==== hw/clkdiv_rst_sync.sv ====
// Release is synchronous to clk_i after two edges; test mode hands the raw pad reset to scan
`default_nettype none

module clkdiv_rst_sync
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic test_mode_i,
    output logic rstn_o
);

    // Two-flop release chain, index 1 is the output stage
    logic [1:0] reg_rst_chain;

    //////////////////////////////
    // Synchronous release
    //////////////////////////////

    // Assertion clears the chain at once
    // Deassertion walks a one through both flops
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            reg_rst_chain <= 2'b00;
        end
        else
        begin
            reg_rst_chain <= {reg_rst_chain[0], 1'b1};
        end
    end

    // Scan tester drives reset directly in test mode
    assign rstn_o = test_mode_i ? rstn_i : reg_rst_chain[1];

endmodule

`default_nettype wire

// ==== hw/clkdiv_top.sv ====
// Host must hold data stable until ack rises and wait for ack low before the next request
`default_nettype none

module clkdiv_top
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 test_mode_i,
    input  logic                 clk_gate_async_i,
    input  logic                 clk_div_valid_i,
    input  clkdiv_cfg_pkg::div_t clk_div_data_i,
    output logic                 clk_div_ack_o,
    output clkdiv_cfg_pkg::div_t clk_div_data_o,
    output logic                 clk_o
);

    // Reset and handshake
    logic s_rstn_sync;
    logic s_req_edge;

    // Ratio register and control FSM
    clkdiv_cfg_pkg::div_t    reg_clk_div;
    clkdiv_ctrl_pkg::state_t reg_state;
    clkdiv_ctrl_pkg::state_t s_state_next;
    logic                    s_fsm_en;
    logic                    s_div_load;

    // Clock path
    logic [clkdiv_ctrl_pkg::SYNC_STAGES-1:0] reg_gate_sync;
    logic                                    s_gate_en;
    logic                                    s_clk_div;

    //////////////////////////////
    // Reset and request sync
    //////////////////////////////

    clkdiv_rst_sync i_rst_sync
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .test_mode_i (test_mode_i),
        .rstn_o      (s_rstn_sync)
    );

    // Ack is the synchronized request level
    clkdiv_req_sync i_req_sync
    (
        .clk_i    (clk_i),
        .rstn_i   (s_rstn_sync),
        .serial_i (clk_div_valid_i),
        .serial_o (clk_div_ack_o),
        .r_edge_o (s_req_edge)
    );

    //////////////////////////////
    // Ratio register
    //////////////////////////////

    // Data is stable under the handshake when the edge arrives
    always_ff @(posedge clk_i or negedge s_rstn_sync)
    begin
        if (!s_rstn_sync)
        begin
            reg_clk_div <= clkdiv_cfg_pkg::DIV_INIT;
        end
        else if (s_req_edge)
        begin
            reg_clk_div <= clk_div_data_i;
        end
    end

    assign clk_div_data_o = reg_clk_div;

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    // Clock stays gated from the load through two settle cycles
    always_comb
    begin
        s_fsm_en     = 1'b0;
        s_div_load   = 1'b0;
        s_state_next = reg_state;
        case (reg_state)
            clkdiv_ctrl_pkg::IDLE:
            begin
                s_fsm_en = 1'b1;
                if (s_req_edge)
                begin
                    s_state_next = clkdiv_ctrl_pkg::STOP;
                end
            end
            clkdiv_ctrl_pkg::STOP:
            begin
                s_div_load   = 1'b1;
                s_state_next = clkdiv_ctrl_pkg::WAIT;
            end
            clkdiv_ctrl_pkg::WAIT:
            begin
                s_state_next = clkdiv_ctrl_pkg::RELEASE;
            end
            default:
            begin
                s_state_next = clkdiv_ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge s_rstn_sync)
    begin
        if (!s_rstn_sync)
        begin
            reg_state <= clkdiv_ctrl_pkg::IDLE;
        end
        else
        begin
            reg_state <= s_state_next;
        end
    end

    //////////////////////////////
    // Clock path
    //////////////////////////////

    // External gate sync, resets open so the clock runs after reset
    always_ff @(posedge clk_i or negedge s_rstn_sync)
    begin
        if (!s_rstn_sync)
        begin
            reg_gate_sync <= '1;
        end
        else
        begin
            reg_gate_sync <= {reg_gate_sync[clkdiv_ctrl_pkg::SYNC_STAGES-2:0], clk_gate_async_i};
        end
    end

    assign s_gate_en = s_fsm_en & reg_gate_sync[clkdiv_ctrl_pkg::SYNC_STAGES-1];

    clkdiv_counter i_counter
    (
        .clk_i       (clk_i),
        .rstn_i      (s_rstn_sync),
        .test_mode_i (test_mode_i),
        .load_i      (s_div_load),
        .div_i       (reg_clk_div),
        .clk_o       (s_clk_div)
    );

    // Test mode forces the gate open
    clkdiv_clk_gate i_clk_gate
    (
        .clk_i     (s_clk_div),
        .en_i      (s_gate_en),
        .test_en_i (test_mode_i),
        .clk_o     (clk_o)
    );

endmodule

`default_nettype wire

// ==== verification/clkdiv_assert.sv ====
// Checks hold only outside reset; the request must be driven synchronous to nothing but stay level
`default_nettype none

module clkdiv_assert
(
    input logic                    clk_i,
    input logic                    rstn_i,
    input clkdiv_ctrl_pkg::state_t state_i,
    input logic                    load_i,
    input logic                    req_i,
    input logic                    ack_i
);

    // Failure count read back by the testbench at the end
    int unsigned fail_cnt = 0;

    //////////////////////////////
    // FSM sequence
    //////////////////////////////

    stop_then_wait: assert property (@(posedge clk_i) disable iff (!rstn_i)
        state_i == clkdiv_ctrl_pkg::STOP |=> state_i == clkdiv_ctrl_pkg::WAIT)
    else
    begin
        $error("FSM left STOP for a state other than WAIT");
        fail_cnt++;
    end

    wait_then_release: assert property (@(posedge clk_i) disable iff (!rstn_i)
        state_i == clkdiv_ctrl_pkg::WAIT |=> state_i == clkdiv_ctrl_pkg::RELEASE)
    else
    begin
        $error("FSM left WAIT for a state other than RELEASE");
        fail_cnt++;
    end

    release_then_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        state_i == clkdiv_ctrl_pkg::RELEASE |=> state_i == clkdiv_ctrl_pkg::IDLE)
    else
    begin
        $error("FSM left RELEASE for a state other than IDLE");
        fail_cnt++;
    end

    // Counter load only while the gate is closed
    load_in_stop: assert property (@(posedge clk_i) disable iff (!rstn_i)
        load_i |-> state_i == clkdiv_ctrl_pkg::STOP)
    else
    begin
        $error("Load strobe outside STOP");
        fail_cnt++;
    end

    //////////////////////////////
    // Handshake echo
    //////////////////////////////

    // New ack level is the request seen SYNC_STAGES plus one edges earlier
    ack_follows_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$stable(ack_i) |-> ack_i == $past(req_i, clkdiv_ctrl_pkg::SYNC_STAGES + 1))
    else
    begin
        $error("Acknowledge moved without a matching request change");
        fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== verification/clkdiv_clk_gen.sv ====
// Free-running clock of period 100, reset low for the first 4 cycles and released on a falling edge
`default_nettype none

module clkdiv_clk_gen
(
    output logic clk_o,
    output logic rstn_o
);

    localparam time HALF_PERIOD  = 50;
    localparam int  RESET_CYCLES = 4;

    initial
    begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial
    begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/clkdiv_tb.sv ====
// Edge times are taken from clk_o itself; bypass rows expect the clk_i high phase of 50 units
`default_nettype none

module clkdiv_tb;

    localparam time CLK_PERIOD = 100;
    localparam int  HS_TIMEOUT = 16;
    localparam int  SEED       = 18346;
    localparam int  RAND_ROWS  = 3;

    // One table row, exp_period of 0 means clk_o must stay low
    typedef struct {
        bit                   write;
        clkdiv_cfg_pkg::div_t ratio;
        bit                   gate;
        bit                   scan;
        int                   exp_period;
    } row_t;

    logic                 clk;
    logic                 rstn;
    logic                 test_mode;
    logic                 clk_gate_async;
    logic                 clk_div_valid;
    clkdiv_cfg_pkg::div_t clk_div_data;
    logic                 clk_div_ack;
    clkdiv_cfg_pkg::div_t clk_div_data_out;
    logic                 clk_out;

    row_t        rows_q[$];
    time         rise_q[$];
    time         fall_q[$];
    int unsigned err_cnt;

    clkdiv_clk_gen i_clk_gen
    (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    clkdiv_top dut_i
    (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .test_mode_i      (test_mode),
        .clk_gate_async_i (clk_gate_async),
        .clk_div_valid_i  (clk_div_valid),
        .clk_div_data_i   (clk_div_data),
        .clk_div_ack_o    (clk_div_ack),
        .clk_div_data_o   (clk_div_data_out),
        .clk_o            (clk_out)
    );

    bind clkdiv_top clkdiv_assert i_assert
    (
        .clk_i   (clk_i),
        .rstn_i  (s_rstn_sync),
        .state_i (reg_state),
        .load_i  (s_div_load),
        .req_i   (clk_div_valid_i),
        .ack_i   (clk_div_ack_o)
    );

    // Edge log of the output clock, scanned after each window
    always @(posedge clk_out) rise_q.push_back($time);
    always @(negedge clk_out) fall_q.push_back($time);

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic add_row(input bit write, input clkdiv_cfg_pkg::div_t ratio, input bit gate,
                           input bit scan, input int exp_period);
        row_t r;
        r.write      = write;
        r.ratio      = ratio;
        r.gate       = gate;
        r.scan       = scan;
        r.exp_period = exp_period;
        rows_q.push_back(r);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Index of the first logged edge later than t, or -1
    function automatic int find_rise(input time t);
        int idx;
        idx = -1;
        for (int k = rise_q.size() - 1; k >= 0 && rise_q[k] > t; k--)
            idx = k;
        return idx;
    endfunction

    function automatic int find_fall(input time t);
        int idx;
        idx = -1;
        for (int k = fall_q.size() - 1; k >= 0 && fall_q[k] > t; k--)
            idx = k;
        return idx;
    endfunction

    // Four-phase write, data set one edge ahead of the request
    task automatic send_ratio(input int row, input clkdiv_cfg_pkg::div_t ratio);
        int cyc;
        @(negedge clk);
        clk_div_data = ratio;
        @(negedge clk);
        clk_div_valid = 1'b1;
        cyc = 0;
        while (clk_div_ack !== 1'b1 && cyc < HS_TIMEOUT)
        begin
            @(negedge clk);
            cyc++;
        end
        assert (clk_div_ack === 1'b1)
        else
        begin
            $display("row %0d: timeout waiting for the acknowledge to rise", row);
            err_cnt++;
        end
        clk_div_valid = 1'b0;
        cyc = 0;
        while (clk_div_ack !== 1'b0 && cyc < HS_TIMEOUT)
        begin
            @(negedge clk);
            cyc++;
        end
        assert (clk_div_ack === 1'b0)
        else
        begin
            $display("row %0d: timeout waiting for the acknowledge to fall", row);
            err_cnt++;
        end
    endtask

    // Three full output periods, each N cycles long and high for floor(N/2)
    task automatic check_running(input int row, input int exp_period);
        time t0;
        time exp_time;
        time exp_high;
        time period;
        time high;
        int  first;
        int  fidx;
        int  cyc;
        t0       = $time;
        exp_time = CLK_PERIOD * time'(exp_period);
        // Bypass shows the clk_i high phase
        exp_high = (exp_period > 1) ? CLK_PERIOD * time'(exp_period / 2) : CLK_PERIOD / 2;
        first    = -1;
        cyc      = 0;
        while (!(first >= 0 && rise_q.size() >= first + 4) && cyc < 4 * exp_period + 8)
        begin
            @(negedge clk);
            cyc++;
            first = find_rise(t0);
        end
        assert (first >= 0 && rise_q.size() >= first + 4)
        else
        begin
            $display("row %0d: timeout, clk_o did not toggle within the window", row);
            err_cnt++;
            return;
        end
        for (int k = 0; k < 3; k++)
        begin
            period = rise_q[first + k + 1] - rise_q[first + k];
            fidx   = find_fall(rise_q[first + k]);
            high   = (fidx >= 0) ? fall_q[fidx] - rise_q[first + k] : 0;
            assert (period == exp_time)
            else
            begin
                $display("error at %0t: row %0d period %0t, expected %0t",
                         $time, row, period, exp_time);
                err_cnt++;
            end
            assert (high == exp_high)
            else
            begin
                $display("error at %0t: row %0d high time %0t, expected %0t",
                         $time, row, high, exp_high);
                err_cnt++;
            end
        end
    endtask

    // Gated output stays low with no rising edge over the window
    task automatic check_stopped(input int row, input int window);
        time t0;
        bit  low_ok;
        t0     = $time;
        low_ok = 1'b1;
        for (int cyc = 0; cyc < window; cyc++)
        begin
            @(negedge clk);
            if (clk_out !== 1'b0)
                low_ok = 1'b0;
        end
        assert (low_ok && find_rise(t0) < 0)
        else
        begin
            $display("error at %0t: row %0d clk_o toggled while gated", $time, row);
            err_cnt++;
        end
    endtask

    //////////////////////////////
    // Table run
    //////////////////////////////

    initial
    begin
        row_t                 r;
        int                   cyc;
        int                   span;
        int unsigned          row_start;
        int unsigned          bad_rows;
        clkdiv_cfg_pkg::div_t rnd;

        test_mode      = 1'b0;
        clk_gate_async = 1'b1;
        clk_div_valid  = 1'b0;
        clk_div_data   = '0;
        err_cnt        = 0;
        bad_rows       = 0;
        void'($urandom(SEED));

        // Columns: write, ratio seen on clk_div_data_o, gate, test mode, period
        add_row(1'b0, 8'd0, 1'b1, 1'b0, 1);
        add_row(1'b1, 8'd2, 1'b1, 1'b0, 2);
        add_row(1'b1, 8'd5, 1'b1, 1'b0, 5);
        add_row(1'b1, 8'd8, 1'b1, 1'b0, 8);
        add_row(1'b1, 8'd1, 1'b1, 1'b0, 1);
        add_row(1'b1, 8'd3, 1'b1, 1'b0, 3);
        add_row(1'b1, 8'd0, 1'b1, 1'b0, 1);
        add_row(1'b1, 8'd6, 1'b0, 1'b0, 0);
        add_row(1'b0, 8'd6, 1'b1, 1'b0, 6);
        add_row(1'b1, 8'd4, 1'b0, 1'b1, 1);
        add_row(1'b0, 8'd4, 1'b0, 1'b0, 0);
        add_row(1'b0, 8'd4, 1'b1, 1'b0, 4);
        // Random ratios all divide, so the period is the ratio itself
        for (int k = 0; k < RAND_ROWS; k++)
        begin
            rnd = clkdiv_cfg_pkg::div_t'($urandom_range(255, 2));
            add_row(1'b1, rnd, 1'b1, 1'b0, int'(rnd));
        end

        cyc = 0;
        while (rstn !== 1'b1 && cyc < 20)
        begin
            @(negedge clk);
            cyc++;
        end
        assert (rstn === 1'b1)
        else
        begin
            $display("reset was never released");
            err_cnt++;
        end
        // Synchronized reset follows two edges later
        idle_cycles(4);

        foreach (rows_q[idx])
        begin
            r         = rows_q[idx];
            row_start = err_cnt;
            @(negedge clk);
            test_mode      = r.scan;
            clk_gate_async = r.gate;
            if (r.write)
                send_ratio(idx, r.ratio);
            // Slow divided clock finishes its high phase before the gate settles
            span = (r.ratio < 8'd2) ? 2 : int'(r.ratio);
            idle_cycles(2 * span + 6);
            assert (clk_div_data_out === r.ratio)
            else
            begin
                $display("error at %0t: row %0d ratio register %0d, expected %0d",
                         $time, idx, clk_div_data_out, r.ratio);
                err_cnt++;
            end
            if (r.exp_period == 0)
                check_stopped(idx, 3 * span + 8);
            else
                check_running(idx, r.exp_period);
            if (err_cnt == row_start)
                $display("row %0d ratio %0d gate %0d scan %0d: passed", idx, r.ratio, r.gate, r.scan);
            else
            begin
                bad_rows++;
                $display("row %0d ratio %0d gate %0d scan %0d: failed", idx, r.ratio, r.gate, r.scan);
            end
        end

        err_cnt = err_cnt + dut_i.i_assert.fail_cnt;
        $display("rows %0d, failed rows %0d, errors %0d", rows_q.size(), bad_rows, err_cnt);
        if (err_cnt == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
